// File: filelist.f
hw/wb_pkg.sv
hw/wb_pipe_reg.sv
hw/mem_access_classify.sv
hw/flow_classify.sv
hw/retire_record.sv
hw/wb_unit.sv
testbench/tb_wb_unit.sv

// File: testbench/tb_wb_unit.sv
`timescale 1ns/1ps

module tb_wb_unit;

	localparam int N_INSTR = 64;

	logic                  clk;
	logic                  rst;
	logic                  stall;
	logic                  in_valid;
	wb_pkg::wb_in_t        in_rec;
	logic                  gpr_we;
	wb_pkg::reg_id_t       gpr_rd;
	wb_pkg::xword_t        gpr_wdata;
	logic                  retire_valid;
	wb_pkg::retire_t       retire;
	wb_pkg::retire_count_t retired;

	wb_pkg::wb_in_t recs [N_INSTR];
	int             stall_len [N_INSTR];
	int             total_stall;
	integer         seed = 59;
	int             mismatch_count = 0;
	int             other_count = 0;
	longint         watchdog_ns;
	logic           limit_ready = 1'b0;

	// Model of the stage: records waiting in MEM/WB, then one retire slot.
	wb_pkg::wb_in_t stage_q [$];
	wb_pkg::wb_in_t exp_rec;
	logic           exp_ret_v;
	logic [63:0]    exp_seq;
	logic [63:0]    done_count;

	wb_unit wb_unit_i (
		.clk          (clk),
		.rst          (rst),
		.stall        (stall),
		.in_valid     (in_valid),
		.in_rec       (in_rec),
		.gpr_we       (gpr_we),
		.gpr_rd       (gpr_rd),
		.gpr_wdata    (gpr_wdata),
		.retire_valid (retire_valid),
		.retire       (retire),
		.retired      (retired)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic next_cycle();
		@(posedge clk);
		#5;
	endtask

	task automatic check_value(input string what, input logic [63:0] got,
		input logic [63:0] exp);
		assert (got === exp) else begin
			mismatch_count++;
			$display("mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	function automatic logic expect_write(wb_pkg::wb_in_t r);
		logic no_reg;
		no_reg = r.op_class[wb_pkg::OPC_BRANCH] | r.op_class[wb_pkg::OPC_STORE] |
			r.op_class[wb_pkg::OPC_FENCE] | r.op_class[wb_pkg::OPC_SYSTEM];
		return !no_reg && (r.rd != 5'd0);
	endfunction

	function automatic wb_pkg::mem_info_t expect_mem(wb_pkg::wb_in_t r);
		wb_pkg::mem_info_t m;
		logic [2:0]        f3;
		m = '0;
		f3 = r.inst[14:12];
		if (r.inst[6:0] == wb_pkg::OPCODE_LOAD && f3 != 3'b111) begin
			m.kind      = wb_pkg::MEM_LOAD;
			m.size      = f3[1:0];
			m.is_signed = (f3 < 3'd4);  // lbu, lhu, lwu are unsigned.
			m.addr      = r.raddr;
		end else if (r.inst[6:0] == wb_pkg::OPCODE_STORE && f3 < 3'd4) begin
			m.kind      = wb_pkg::MEM_STORE;
			m.size      = f3[1:0];
			m.is_signed = 1'b1;
			m.addr      = r.waddr;
		end
		return m;
	endfunction

	function automatic wb_pkg::flow_info_t expect_flow(wb_pkg::wb_in_t r);
		wb_pkg::flow_info_t f;
		logic               rd_link;
		logic               rs1_link;
		longint             off;
		f = '0;
		rd_link  = (r.inst[11:7] == 5'd1) || (r.inst[11:7] == 5'd5);
		rs1_link = (r.inst[19:15] == 5'd1) || (r.inst[19:15] == 5'd5);
		if (r.inst[6:0] == wb_pkg::OPCODE_JAL) begin
			off = {r.inst[31], r.inst[19:12], r.inst[20], r.inst[30:21], 1'b0};
			if (r.inst[31]) off = off - 2097152;  // 21-bit two's complement.
			f.offset = off;
			f.kind   = rd_link ? wb_pkg::FLOW_CALL : wb_pkg::FLOW_JUMP;
		end else if (r.inst[6:0] == wb_pkg::OPCODE_JALR) begin
			off = r.inst[31:20];
			if (r.inst[31]) off = off - 4096;
			f.offset = off;
			if (rd_link)
				f.kind = wb_pkg::FLOW_CALL;
			else if (r.inst[11:7] == 5'd0 && rs1_link && r.inst[31:20] == 12'd0)
				f.kind = wb_pkg::FLOW_RET;
			else
				f.kind = wb_pkg::FLOW_JUMP;
		end
		return f;
	endfunction

	// First 16 sweep every load and store funct3, the rest is random.
	task automatic make_record(input int idx, output wb_pkg::wb_in_t r);
		logic [31:0] w;
		int          kind;
		int          cls;
		int          sel;
		w    = $random(seed);
		kind = (idx < 16) ? idx / 8 : $unsigned($random(seed)) % 8;
		sel  = $unsigned($random(seed)) % 6;
		case (kind)
			0: begin
				w[6:0] = wb_pkg::OPCODE_LOAD;
				if (idx < 16) w[14:12] = idx[2:0];
				cls = wb_pkg::OPC_LOAD;
			end
			1: begin
				w[6:0] = wb_pkg::OPCODE_STORE;
				if (idx < 16) w[14:12] = idx[2:0];
				cls = wb_pkg::OPC_STORE;
			end
			2: begin
				w[6:0] = wb_pkg::OPCODE_JAL;
				if (sel < 2) w[11:7] = (sel == 0) ? 5'd1 : 5'd5;
				cls = wb_pkg::OPC_JAL;
			end
			3: begin
				w[6:0]   = wb_pkg::OPCODE_JALR;
				w[14:12] = 3'b000;
				if (sel == 0) begin
					w[11:7] = w[31] ? 5'd5 : 5'd1;  // Call.
				end else if (sel < 3) begin
					w[11:7]  = 5'd0;               // Return shape.
					w[19:15] = w[25] ? 5'd1 : 5'd5;
					w[31:20] = 12'd0;
				end else if (sel == 3) begin
					w[11:7]  = 5'd0;
					w[19:15] = 5'd1;
					w[20]    = 1'b1;               // Non-zero imm, plain jump.
				end
				cls = wb_pkg::OPC_JALR;
			end
			4: begin
				w[6:0] = 7'b0010011;
				if (w[31]) w[11:7] = 5'd0;
				cls = wb_pkg::OPC_ALU_IMM;
			end
			5: begin
				w[6:0] = 7'b0110011;
				if (w[30]) w[11:7] = 5'd0;
				cls = w[25] ? wb_pkg::OPC_MUL : wb_pkg::OPC_ALU_REG;
			end
			6: begin
				w[6:0] = 7'b1100011;
				cls = wb_pkg::OPC_BRANCH;
			end
			default: begin
				case (sel)
					0: begin
						w[6:0] = 7'b0110111;
						cls = wb_pkg::OPC_LUI;
					end
					1: begin
						w[6:0] = 7'b0010111;
						cls = wb_pkg::OPC_AUIPC;
					end
					2: begin
						w[6:0] = 7'b0011011;
						cls = wb_pkg::OPC_ALU_IMM_W;
					end
					3: begin
						w[6:0] = 7'b1110011;
						cls = wb_pkg::OPC_CSR;
					end
					4: begin
						w[6:0] = 7'b0001111;
						cls = wb_pkg::OPC_FENCE;
					end
					default: begin
						w[6:0] = 7'b1110011;
						cls = wb_pkg::OPC_SYSTEM;
					end
				endcase
			end
		endcase
		r.pc       = {$random(seed), $random(seed)};
		r.pc[1:0]  = 2'b00;
		r.inst     = w;
		r.op_class = 15'd1 << cls;
		r.rd       = w[11:7];
		r.wdata    = {$random(seed), $random(seed)};
		r.raddr    = {$random(seed), $random(seed)};
		r.waddr    = {$random(seed), $random(seed)};
	endtask

	task automatic check_retire(input wb_pkg::wb_in_t r, input logic [63:0] seq);
		wb_pkg::mem_info_t  m;
		wb_pkg::flow_info_t f;
		m = expect_mem(r);
		f = expect_flow(r);
		check_value("retire pc", retire.pc, r.pc);
		check_value("retire inst", retire.inst, r.inst);
		check_value("mem kind", retire.mem.kind, m.kind);
		check_value("mem size", retire.mem.size, m.size);
		check_value("mem is_signed", retire.mem.is_signed, m.is_signed);
		check_value("mem addr", retire.mem.addr, m.addr);
		check_value("flow kind", retire.flow.kind, f.kind);
		check_value("flow offset", retire.flow.offset, f.offset);
		check_value("retire rd", retire.rd, r.rd);
		check_value("writes_gpr", retire.writes_gpr, expect_write(r));
		check_value("retire seq", retire.seq, seq);
	endtask

	// Outputs are read mid-cycle, well away from both clock edge and drive.
	always @(negedge clk) begin
		if (rst !== 1'b0) begin
			stage_q.delete();
			exp_ret_v  = 1'b0;
			done_count = '0;
		end else begin
			check_value("retire_valid", retire_valid, exp_ret_v);
			if (retire_valid && exp_ret_v) check_retire(exp_rec, exp_seq);
			check_value("retired", retired, done_count);
			exp_ret_v = 1'b0;
			if (stage_q.size() > 0 && !stall) begin
				exp_rec    = stage_q.pop_front();  // Completes this cycle.
				exp_seq    = done_count;
				done_count = done_count + 1;
				exp_ret_v  = 1'b1;
				check_value("gpr_we", gpr_we, expect_write(exp_rec));
				if (expect_write(exp_rec)) begin
					check_value("gpr_rd", gpr_rd, exp_rec.rd);
					check_value("gpr_wdata", gpr_wdata, exp_rec.wdata);
				end
			end else begin
				check_value("gpr_we", gpr_we, 1'b0);
			end
			if (in_valid && !stall) stage_q.push_back(in_rec);
		end
	end

	a_stall_no_write: assert property (@(posedge clk) disable iff (rst) stall |-> !gpr_we)
		else begin
			other_count++;
			$display("register write asserted during a stall at %0t", $time);
		end

	a_reset_clears: assert property (@(posedge clk) rst |=> (!retire_valid && retired == '0))
		else begin
			mismatch_count++;
			$display("mismatch at %0t: outputs not cleared by reset", $time);
		end

	initial begin
		wait (limit_ready);
		#(watchdog_ns);
		$display("timeout: not all instructions retired before the watchdog expired");
		$display("ERRORS FOUND");
		$finish;
	end

	initial begin
		rst         = 1'b1;
		stall       = 1'b0;
		in_valid    = 1'b0;
		in_rec      = '0;
		total_stall = 0;
		for (int i = 0; i < N_INSTR; i++) begin
			make_record(i, recs[i]);
			stall_len[i] = ($unsigned($random(seed)) % 4 == 0) ?
				1 + $unsigned($random(seed)) % 4 : 0;
			total_stall += stall_len[i];
		end
		watchdog_ns = (N_INSTR + total_stall + 40) * 100;
		limit_ready = 1'b1;
		repeat (16) next_cycle();
		rst = 1'b0;
		repeat (2) next_cycle();  // Idle, nothing may retire.
		for (int i = 0; i < N_INSTR; i++) begin
			in_rec   = recs[i];
			in_valid = 1'b1;
			next_cycle();
			in_valid = 1'b0;
			for (int k = 0; k < stall_len[i]; k++) begin
				stall = 1'b1;  // Hold the instruction just strobed.
				next_cycle();
			end
			stall = 1'b0;
		end
		in_rec = '0;
		wait (retired == N_INSTR);
		repeat (3) next_cycle();
		if (stage_q.size() != 0 || exp_ret_v) begin
			other_count++;
			$display("instructions left in the model that never retired");
		end
		$display("error counts: %0d mismatches, %0d other errors", mismatch_count,
			other_count);
		if (mismatch_count + other_count == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

// File: hw/wb_unit.sv
`timescale 1ns/1ps

// Writeback stage of the RV64I pipeline.
module wb_unit (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  stall,
	input  logic                  in_valid,
	input  wb_pkg::wb_in_t        in_rec,
	output logic                  gpr_we,
	output wb_pkg::reg_id_t       gpr_rd,
	output wb_pkg::xword_t        gpr_wdata,
	output logic                  retire_valid,
	output wb_pkg::retire_t       retire,
	output wb_pkg::retire_count_t retired
);

	logic               held_valid;
	wb_pkg::wb_in_t     held;
	wb_pkg::mem_info_t  mem_info;
	wb_pkg::flow_info_t flow_info;

	wb_pipe_reg wb_pipe_reg_i (
		.clk        (clk),
		.rst        (rst),
		.stall      (stall),
		.in_valid   (in_valid),
		.in_rec     (in_rec),
		.held_valid (held_valid),
		.held       (held)
	);

	// Both classifiers look at the same held record.
	mem_access_classify mem_access_classify_i (
		.held     (held),
		.mem_info (mem_info)
	);

	flow_classify flow_classify_i (
		.held      (held),
		.flow_info (flow_info)
	);

	retire_record retire_record_i (
		.clk          (clk),
		.rst          (rst),
		.stall        (stall),
		.held_valid   (held_valid),
		.held         (held),
		.mem_info     (mem_info),
		.flow_info    (flow_info),
		.gpr_we       (gpr_we),
		.gpr_rd       (gpr_rd),
		.gpr_wdata    (gpr_wdata),
		.retire_valid (retire_valid),
		.retire       (retire),
		.retired      (retired)
	);

endmodule

// File: hw/retire_record.sv
`timescale 1ns/1ps

// Completion logic of the writeback stage. Drives the register file
// write port in the completion cycle and publishes one registered retire
// record per instruction, numbered by the retired counter.
module retire_record (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  stall,
	input  logic                  held_valid,
	input  wb_pkg::wb_in_t        held,
	input  wb_pkg::mem_info_t     mem_info,
	input  wb_pkg::flow_info_t    flow_info,
	output logic                  gpr_we,
	output wb_pkg::reg_id_t       gpr_rd,
	output wb_pkg::xword_t        gpr_wdata,
	output logic                  retire_valid,
	output wb_pkg::retire_t       retire,
	output wb_pkg::retire_count_t retired
);

	logic complete;
	logic writes_gpr;

	assign complete = held_valid && !stall;  // Leaves the stage now.

	// x0 is hardwired to zero, so it never gets a write.
	assign writes_gpr = (|(held.op_class & wb_pkg::GPR_WRITE_MASK)) &&
		(held.rd != '0);

	assign gpr_we    = complete && writes_gpr;
	assign gpr_rd    = held.rd;
	assign gpr_wdata = held.wdata;

	always_ff @(posedge clk) begin
		if (rst) begin
			retire_valid <= 1'b0;
			retired      <= '0;
		end else begin
			retire_valid <= complete;  // One pulse per instruction.
			if (complete) begin
				retired <= retired + 1'b1;
			end
		end
	end

	// Trace payload.
	always_ff @(posedge clk) begin
		if (complete) begin
			retire.pc         <= held.pc;
			retire.inst       <= held.inst;
			retire.mem        <= mem_info;
			retire.flow       <= flow_info;
			retire.rd         <= held.rd;
			retire.writes_gpr <= writes_gpr;
			retire.seq        <= retired;  // Count before this retire.
		end
	end

	property p_no_x0_write;
		@(posedge clk) disable iff (rst)
		gpr_we |-> (gpr_rd != '0);
	endproperty

	a_no_x0_write: assert property (p_no_x0_write)
		else $error("retire_record: write to x0");

	// A stalled cycle never completes anything, so the cycle after it
	// cannot carry a retire pulse.
	property p_no_retire_after_stall;
		@(posedge clk) disable iff (rst)
		stall |=> !retire_valid;
	endproperty

	a_no_retire_after_stall: assert property (p_no_retire_after_stall)
		else $error("retire_record: retire following a stall cycle");

endmodule

// File: hw/flow_classify.sv
`timescale 1ns/1ps

// Sorts jal and jalr into call, return or plain jump for the function
// trace, following the RISC-V link register hints.
module flow_classify (
	input  wb_pkg::wb_in_t     held,
	output wb_pkg::flow_info_t flow_info
);

	logic [6:0]       opcode;
	wb_pkg::reg_id_t  rd;
	wb_pkg::reg_id_t  rs1;
	logic [20:0]      j_imm;
	logic [11:0]      i_imm;
	wb_pkg::xword_t   j_offset;
	wb_pkg::xword_t   i_offset;
	logic             rd_link;
	logic             rs1_link;

	assign opcode = held.inst[6:0];
	assign rd     = held.inst[11:7];
	assign rs1    = held.inst[19:15];

	// J-type immediate is scattered over the word.
	assign j_imm = {held.inst[31], held.inst[19:12], held.inst[20],
		held.inst[30:21], 1'b0};
	assign i_imm = held.inst[31:20];

	assign j_offset = {{(wb_pkg::XLEN-21){j_imm[20]}}, j_imm};
	assign i_offset = {{(wb_pkg::XLEN-12){i_imm[11]}}, i_imm};

	// ra or t0 act as link registers.
	assign rd_link  = (rd == wb_pkg::RA_REG) || (rd == wb_pkg::ALT_LINK_REG);
	assign rs1_link = (rs1 == wb_pkg::RA_REG) || (rs1 == wb_pkg::ALT_LINK_REG);

	always_comb begin
		flow_info = '0;
		case (opcode)
			wb_pkg::OPCODE_JAL: begin
				flow_info.offset = j_offset;
				if (rd_link) begin
					flow_info.kind = wb_pkg::FLOW_CALL;
				end else begin
					flow_info.kind = wb_pkg::FLOW_JUMP;
				end
			end
			wb_pkg::OPCODE_JALR: begin
				flow_info.offset = i_offset;
				if (rd_link) begin
					flow_info.kind = wb_pkg::FLOW_CALL;  // Link wins over return.
				end else if (rd == '0 && rs1_link && i_imm == '0) begin
					flow_info.kind = wb_pkg::FLOW_RET;   // jr ra.
				end else begin
					flow_info.kind = wb_pkg::FLOW_JUMP;
				end
			end
			default: begin
				flow_info = '0;
			end
		endcase
	end

endmodule

// File: hw/mem_access_classify.sv
`timescale 1ns/1ps

// Decodes the held instruction for the memory trace. Load and store are
// recognised from the opcode and funct3, the address comes from the
// memory stage record.
module mem_access_classify (
	input  wb_pkg::wb_in_t    held,
	output wb_pkg::mem_info_t mem_info
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic       is_load;
	logic       is_store;

	assign opcode = held.inst[6:0];
	assign funct3 = held.inst[14:12];

	// lb lh lw ld lbu lhu lwu; funct3 111 is not a load.
	always_comb begin
		is_load = 1'b0;
		if (opcode == wb_pkg::OPCODE_LOAD) begin
			is_load = (funct3 != 3'b111);
		end
	end

	// sb sh sw sd.
	always_comb begin
		is_store = 1'b0;
		if (opcode == wb_pkg::OPCODE_STORE) begin
			is_store = !funct3[2];
		end
	end

	always_comb begin
		mem_info = '0;
		if (is_load) begin
			mem_info.kind = wb_pkg::MEM_LOAD;
			mem_info.addr = held.raddr;
		end else if (is_store) begin
			mem_info.kind = wb_pkg::MEM_STORE;
			mem_info.addr = held.waddr;
		end

		if (is_load || is_store) begin
			mem_info.size      = funct3[1:0];  // Byte to doubleword.
			mem_info.is_signed = ~funct3[2];   // Unsigned loads set bit 2.
		end
	end

	// Code 3 has no meaning for the memory kind.
	a_kind_legal: assert final (mem_info.kind !== 2'd3)
		else $error("mem_access_classify: illegal memory kind");

endmodule

// File: hw/wb_pipe_reg.sv
`timescale 1ns/1ps

// MEM/WB boundary register. The record moves in whenever the downstream
// side is not stalled, otherwise the current contents stay put.
module wb_pipe_reg (
	input  logic           clk,
	input  logic           rst,
	input  logic           stall,
	input  logic           in_valid,
	input  wb_pkg::wb_in_t in_rec,
	output logic           held_valid,
	output wb_pkg::wb_in_t held
);

	logic load_en;

	assign load_en = !stall;  // Stage advances.

	// Valid bit is control state.
	always_ff @(posedge clk) begin
		if (rst) begin
			held_valid <= 1'b0;
		end else if (load_en) begin
			held_valid <= in_valid;
		end
	end

	// Record payload.
	always_ff @(posedge clk) begin
		if (load_en) begin
			held <= in_rec;
		end
	end

	// A held instruction must not change under the writeback stage
	// while the stall lasts, or it would retire with a different record.
	property p_hold_under_stall;
		@(posedge clk) disable iff (rst)
		(stall && held_valid) |=> (held_valid && $stable(held));
	endproperty

	a_hold_under_stall: assert property (p_hold_under_stall)
		else $error("wb_pipe_reg: held record changed during stall");

	// Nothing may be offered while the stage is stalled.
	property p_no_input_in_stall;
		@(posedge clk) disable iff (rst)
		(stall && held_valid) |-> !in_valid;
	endproperty

	a_no_input_in_stall: assert property (p_no_input_in_stall)
		else $error("wb_pipe_reg: input strobe while stalled");

endmodule

// File: hw/wb_pkg.sv
package wb_pkg;

	localparam int XLEN = 64;

	typedef logic [XLEN-1:0] xword_t;        // Data or address word.
	typedef logic [31:0]     inst_t;
	typedef logic [4:0]      reg_id_t;
	typedef logic [14:0]     op_class_t;     // One-hot class from decode.
	typedef logic [1:0]      access_size_t;  // log2 of bytes.
	typedef logic [63:0]     retire_count_t;

	// Bit positions inside op_class_t
	localparam int OPC_LUI       = 0;
	localparam int OPC_AUIPC     = 1;
	localparam int OPC_JAL       = 2;
	localparam int OPC_JALR      = 3;
	localparam int OPC_BRANCH    = 4;
	localparam int OPC_LOAD      = 5;
	localparam int OPC_STORE     = 6;
	localparam int OPC_ALU_IMM   = 7;
	localparam int OPC_ALU_REG   = 8;
	localparam int OPC_ALU_IMM_W = 9;
	localparam int OPC_ALU_REG_W = 10;
	localparam int OPC_CSR       = 11;
	localparam int OPC_FENCE     = 12;
	localparam int OPC_SYSTEM    = 13;
	localparam int OPC_MUL       = 14;

	// Branch, store, fence and system leave the register file alone.
	localparam op_class_t GPR_WRITE_MASK =
		op_class_t'((15'd1 << OPC_LUI) | (15'd1 << OPC_AUIPC) |
		(15'd1 << OPC_JAL) | (15'd1 << OPC_JALR) | (15'd1 << OPC_LOAD) |
		(15'd1 << OPC_ALU_IMM) | (15'd1 << OPC_ALU_REG) |
		(15'd1 << OPC_ALU_IMM_W) | (15'd1 << OPC_ALU_REG_W) |
		(15'd1 << OPC_CSR) | (15'd1 << OPC_MUL));

	localparam reg_id_t RA_REG       = 5'd1;  // x1, ra.
	localparam reg_id_t ALT_LINK_REG = 5'd5;  // x5, t0.

	localparam logic [6:0] OPCODE_LOAD  = 7'b0000011;
	localparam logic [6:0] OPCODE_STORE = 7'b0100011;
	localparam logic [6:0] OPCODE_JAL   = 7'b1101111;
	localparam logic [6:0] OPCODE_JALR  = 7'b1100111;

	typedef logic [1:0] mem_kind_t;
	localparam mem_kind_t MEM_NONE  = 2'd0;
	localparam mem_kind_t MEM_LOAD  = 2'd1;
	localparam mem_kind_t MEM_STORE = 2'd2;

	typedef logic [1:0] flow_kind_t;
	localparam flow_kind_t FLOW_NONE = 2'd0;
	localparam flow_kind_t FLOW_CALL = 2'd1;
	localparam flow_kind_t FLOW_RET  = 2'd2;
	localparam flow_kind_t FLOW_JUMP = 2'd3;

	typedef struct packed {
		xword_t    pc;
		inst_t     inst;
		op_class_t op_class;
		reg_id_t   rd;
		xword_t    wdata;
		xword_t    raddr;  // Load address used by the memory stage.
		xword_t    waddr;  // Store address used by the memory stage.
	} wb_in_t;

	typedef struct packed {
		mem_kind_t    kind;
		access_size_t size;
		logic         is_signed;
		xword_t       addr;
	} mem_info_t;

	typedef struct packed {
		flow_kind_t kind;
		xword_t     offset;  // Sign-extended jump immediate.
	} flow_info_t;

	typedef struct packed {
		xword_t        pc;
		inst_t         inst;
		mem_info_t     mem;
		flow_info_t    flow;
		reg_id_t       rd;
		logic          writes_gpr;
		retire_count_t seq;  // Retire count before this one.
	} retire_t;

endpackage
